//--- verilog/decoder_cfg_pkg.sv
`default_nettype none

package decoder_cfg_pkg;

    // stream byte and the word it is packed into
    localparam int BYTE_W = 8;
    localparam int BYTES_PER_WORD = 8;
    localparam int WORD_W = BYTE_W * BYTES_PER_WORD;

    // index of a byte slot inside one word
    localparam int SLOT_W = $clog2(BYTES_PER_WORD);

    // one sparsity map covers this many channels
    localparam int CHANNELS_PER_GROUP = 8;
    localparam int OFFSET_W = $clog2(CHANNELS_PER_GROUP);

    // layer geometry
    localparam int CHANNEL_W = 10;
    localparam int MAX_COLUMNS = 256;
    localparam int COLUMN_W = $clog2(MAX_COLUMNS);

endpackage

`default_nettype wire

//--- verilog/stream_format_pkg.sv
`default_nettype none

package stream_format_pkg;

    // bit 0 of the array is the msb and stands for channel offset 0
    typedef logic [0:decoder_cfg_pkg::CHANNELS_PER_GROUP-1] sparsity_map_t;

    // a stream byte is either a map or an activation, depending on
    // where the decoder is inside the group
    typedef union packed {
        sparsity_map_t                        sparsity_map;
        logic [decoder_cfg_pkg::BYTE_W-1:0]   activation;
    } stream_byte_u;

endpackage

`default_nettype wire

//--- verilog/stream_word_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module stream_word_buffer (
    input  wire logic                                 clk,
    input  wire logic                                 resetn,
    input  wire logic [decoder_cfg_pkg::WORD_W-1:0]   i_stream_data,
    input  wire logic                                 i_stream_valid,
    output logic                                      o_stream_ready,
    input  wire logic                                 i_consume,
    input  wire logic                                 i_flush,
    output stream_format_pkg::stream_byte_u           o_head,
    output logic                                      o_head_valid
);

    import decoder_cfg_pkg::*;

    logic [WORD_W-1:0] word_q;
    logic [SLOT_W-1:0] slot_q;
    logic              full_q;
    logic              load;
    logic              last_slot;

    // a new word is only requested once the previous one is used up
    always_comb begin
        o_stream_ready = !full_q;
        load = !full_q && i_stream_valid;
        last_slot = (slot_q == SLOT_W'(BYTES_PER_WORD - 1));
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            full_q <= 1'b0;
            slot_q <= '0;
        end else if (load) begin
            full_q <= 1'b1;
            slot_q <= '0;
        end else if (full_q && i_flush) begin
            full_q <= 1'b0;
            slot_q <= '0;
        end else if (full_q && i_consume) begin
            slot_q <= slot_q + 1'b1;
            if (last_slot) begin
                full_q <= 1'b0;
            end
        end
    end

    // head byte always sits in the top slot
    always_ff @(posedge clk) begin
        if (load) begin
            word_q <= i_stream_data;
        end else if (full_q && i_consume) begin
            word_q <= word_q << BYTE_W;
        end
    end

    always_comb begin
        o_head = word_q[WORD_W-1 -: BYTE_W];
        o_head_valid = full_q;
    end

endmodule

`default_nettype wire

//--- verilog/sparsity_map_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module sparsity_map_decoder (
    input  wire logic                                   clk,
    input  wire logic                                   resetn,
    input  wire stream_format_pkg::sparsity_map_t       i_map,
    input  wire logic                                   i_load,
    input  wire logic                                   i_take,
    output logic                                        o_map_zero,
    output logic [decoder_cfg_pkg::OFFSET_W-1:0]        o_offset,
    output logic                                        o_last_offset
);

    import decoder_cfg_pkg::*;
    import stream_format_pkg::*;

    sparsity_map_t       mask_q;
    sparsity_map_t       mask_next;
    logic [OFFSET_W-1:0] offset;

    // leading one, lowest array index wins since it is offset 0
    always_comb begin
        offset = '0;
        for (int i = CHANNELS_PER_GROUP - 1; i >= 0; i--) begin
            if (mask_q[i]) begin
                offset = OFFSET_W'(i);
            end
        end
    end

    always_comb begin
        mask_next = mask_q;
        mask_next[offset] = 1'b0;
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mask_q <= '0;
        end else if (i_load) begin
            mask_q <= i_map;
        end else if (i_take) begin
            mask_q <= mask_next;
        end
    end

    always_comb begin
        o_map_zero = (i_map == '0);
        o_offset = offset;
        // one bit left means this take closes the group
        o_last_offset = $onehot(mask_q);
    end

endmodule

`default_nettype wire

//--- verilog/layer_position_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module layer_position_tracker (
    input  wire logic                                   clk,
    input  wire logic                                   resetn,
    input  wire logic                                   i_group_done,
    input  wire logic [decoder_cfg_pkg::CHANNEL_W-1:0]  i_num_channels_minus_8,
    input  wire logic [decoder_cfg_pkg::COLUMN_W:0]     i_num_columns,
    output logic [decoder_cfg_pkg::CHANNEL_W-1:0]       o_channel_base,
    output logic [decoder_cfg_pkg::COLUMN_W-1:0]        o_column,
    output logic                                        o_last_column,
    output logic                                        o_layer_done
);

    import decoder_cfg_pkg::*;

    logic [CHANNEL_W-1:0] base_q;
    logic [COLUMN_W-1:0]  column_q;
    logic                 last_group_of_column;
    logic                 last_column;

    always_comb begin
        last_group_of_column = (base_q == i_num_channels_minus_8);
        last_column = ((COLUMN_W + 1)'(column_q) == i_num_columns - 1'b1);
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            base_q <= '0;
            column_q <= '0;
        end else if (i_group_done) begin
            if (last_group_of_column) begin
                base_q <= '0;
                // end of layer starts the next one at column 0
                column_q <= last_column ? '0 : column_q + 1'b1;
            end else begin
                base_q <= base_q + CHANNEL_W'(CHANNELS_PER_GROUP);
            end
        end
    end

    always_comb begin
        o_channel_base = base_q;
        o_column = column_q;
        o_last_column = last_column;
        o_layer_done = last_group_of_column && last_column;
    end

endmodule

`default_nettype wire

//--- verilog/decode_control.sv
`timescale 1ns/1ps
`default_nettype none

module decode_control (
    input  wire logic                                   clk,
    input  wire logic                                   resetn,
    input  wire logic                                   i_start,
    input  wire stream_format_pkg::stream_byte_u        i_head,
    input  wire logic                                   i_head_valid,
    input  wire logic                                   i_map_zero,
    input  wire logic [decoder_cfg_pkg::OFFSET_W-1:0]   i_offset,
    input  wire logic                                   i_last_offset,
    input  wire logic [decoder_cfg_pkg::CHANNEL_W-1:0]  i_channel_base,
    input  wire logic                                   i_layer_done,
    input  wire logic                                   i_value_ready,
    output logic                                        o_consume,
    output logic                                        o_flush,
    output logic                                        o_load,
    output logic                                        o_take,
    output logic                                        o_group_done,
    output logic [decoder_cfg_pkg::BYTE_W-1:0]          o_value,
    output logic [decoder_cfg_pkg::CHANNEL_W-1:0]       o_value_channel,
    output logic                                        o_value_valid
);

    import decoder_cfg_pkg::*;

    // idle: !busy_q, map: busy_q && !value_q, value: busy_q && value_q
    logic busy_q;
    logic value_q;
    logic start_q;
    logic step;

    always_comb begin
        step = busy_q && i_head_valid && i_value_ready;
        o_consume = step;
        o_load = step && !value_q;
        o_take = step && value_q;
        // a group closes on an empty map or on its last value
        o_group_done = (o_load && i_map_zero) || (o_take && i_last_offset);
        o_flush = o_group_done && i_layer_done;
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            start_q <= 1'b0;
        end else if (!busy_q && i_start) begin
            start_q <= 1'b1;
        end else if (o_load) begin
            start_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy_q <= 1'b0;
            value_q <= 1'b0;
        end else if (i_value_ready) begin
            if (!busy_q) begin
                busy_q <= start_q;
                value_q <= 1'b0;
            end else if (o_flush) begin
                busy_q <= 1'b0;
                value_q <= 1'b0;
            end else if (o_load) begin
                value_q <= !i_map_zero;
            end else if (o_group_done) begin
                value_q <= 1'b0;
            end
        end
    end

    // head is read as an activation while in the value state
    always_comb begin
        o_value = i_head.activation;
        o_value_channel = i_channel_base + CHANNEL_W'(i_offset);
        o_value_valid = busy_q && value_q && i_head_valid;
    end

endmodule

`default_nettype wire

//--- verilog/compressed_stream_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module compressed_stream_decoder (
    input  wire logic                                   clk,
    input  wire logic                                   resetn,
    input  wire logic                                   i_start,
    input  wire logic [decoder_cfg_pkg::CHANNEL_W-1:0]  i_num_channels_minus_8,
    input  wire logic [decoder_cfg_pkg::COLUMN_W:0]     i_num_columns,
    input  wire logic [decoder_cfg_pkg::WORD_W-1:0]     i_stream_data,
    input  wire logic                                   i_stream_valid,
    output logic                                        o_stream_ready,
    output logic [decoder_cfg_pkg::BYTE_W-1:0]          o_value,
    output logic [decoder_cfg_pkg::CHANNEL_W-1:0]       o_value_channel,
    output logic [decoder_cfg_pkg::COLUMN_W-1:0]        o_value_column,
    output logic                                        o_value_valid,
    input  wire logic                                   i_value_ready,
    output logic                                        o_last_column
);

    import decoder_cfg_pkg::*;
    import stream_format_pkg::*;

    stream_byte_u         head;
    logic                 head_valid;
    logic                 consume;
    logic                 flush;
    logic                 load;
    logic                 take;
    logic                 map_zero;
    logic [OFFSET_W-1:0]  offset;
    logic                 last_offset;
    logic                 group_done;
    logic [CHANNEL_W-1:0] channel_base;
    logic                 layer_done;

    stream_word_buffer u_buffer (
        .clk            (clk),
        .resetn         (resetn),
        .i_stream_data  (i_stream_data),
        .i_stream_valid (i_stream_valid),
        .o_stream_ready (o_stream_ready),
        .i_consume      (consume),
        .i_flush        (flush),
        .o_head         (head),
        .o_head_valid   (head_valid)
    );

    // the map decoder sees the head byte as a sparsity map
    sparsity_map_decoder u_map_decoder (
        .clk           (clk),
        .resetn        (resetn),
        .i_map         (head.sparsity_map),
        .i_load        (load),
        .i_take        (take),
        .o_map_zero    (map_zero),
        .o_offset      (offset),
        .o_last_offset (last_offset)
    );

    layer_position_tracker u_tracker (
        .clk                    (clk),
        .resetn                 (resetn),
        .i_group_done           (group_done),
        .i_num_channels_minus_8 (i_num_channels_minus_8),
        .i_num_columns          (i_num_columns),
        .o_channel_base         (channel_base),
        .o_column               (o_value_column),
        .o_last_column          (o_last_column),
        .o_layer_done           (layer_done)
    );

    decode_control u_control (
        .clk             (clk),
        .resetn          (resetn),
        .i_start         (i_start),
        .i_head          (head),
        .i_head_valid    (head_valid),
        .i_map_zero      (map_zero),
        .i_offset        (offset),
        .i_last_offset   (last_offset),
        .i_channel_base  (channel_base),
        .i_layer_done    (layer_done),
        .i_value_ready   (i_value_ready),
        .o_consume       (consume),
        .o_flush         (flush),
        .o_load          (load),
        .o_take          (take),
        .o_group_done    (group_done),
        .o_value         (o_value),
        .o_value_channel (o_value_channel),
        .o_value_valid   (o_value_valid)
    );

endmodule

`default_nettype wire

//--- test/stream_model.svh
// words of all layers in send order, with the shape of each layer
logic [63:0] stream_words[$];
int          layer_word_count[$];
int          layer_groups[$];
int          layer_columns[$];

// expected output transfers in stream order
logic [7:0]  exp_value[$];
logic [9:0]  exp_channel[$];
logic [7:0]  exp_column[$];
logic        exp_last[$];

// empty and full maps come up more often than plain random would give
function automatic logic [7:0] random_map();
    int pick;
    pick = int'($urandom % 8);
    if (pick < 2)
        return 8'h00;
    if (pick == 2)
        return 8'hff;
    return 8'($urandom);
endfunction

task automatic build_layer(input int groups, input int columns);
    logic [7:0]  layer_bytes[$];
    logic [7:0]  map_byte;
    logic [7:0]  value;
    logic [63:0] word;
    int          words;
    int          idx;
    for (int col = 0; col < columns; col++) begin
        for (int g = 0; g < groups; g++) begin
            map_byte = random_map();
            layer_bytes.push_back(map_byte);
            // map bit 7 is offset 0
            for (int off = 0; off < 8; off++) begin
                if (map_byte[7 - off]) begin
                    value = 8'($urandom);
                    layer_bytes.push_back(value);
                    exp_value.push_back(value);
                    exp_channel.push_back(10'(g * 8 + off));
                    exp_column.push_back(8'(col));
                    exp_last.push_back(col == columns - 1);
                end
            end
        end
    end
    words = (layer_bytes.size() + 7) / 8;
    idx = 0;
    for (int w = 0; w < words; w++) begin
        word = '0;
        // first byte ends up on top, tail of the last word is random padding
        for (int k = 0; k < 8; k++) begin
            word = {word[55:0], (idx < layer_bytes.size()) ? layer_bytes[idx] : 8'($urandom)};
            idx++;
        end
        stream_words.push_back(word);
    end
    layer_word_count.push_back(words);
    layer_groups.push_back(groups);
    layer_columns.push_back(columns);
endtask

//--- test/tb_compressed_stream_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module tb_compressed_stream_decoder;

    localparam int NUM_LAYERS = 12;

    logic        clk;
    logic        resetn;
    logic        i_start;
    logic [9:0]  i_num_channels_minus_8;
    logic [8:0]  i_num_columns;
    logic [63:0] i_stream_data;
    logic        i_stream_valid;
    logic        o_stream_ready;
    logic [7:0]  o_value;
    logic [9:0]  o_value_channel;
    logic [7:0]  o_value_column;
    logic        o_value_valid;
    logic        i_value_ready;
    logic        o_last_column;

    int          value_errors;
    int          other_errors;
    int          timeout_cycles;
    logic        held;
    logic [25:0] held_output;

    `include "stream_model.svh"

    compressed_stream_decoder dut (.*);

    always #10 clk = ~clk;

    task automatic report_mismatch(input string name, input int expected, input int actual);
        value_errors++;
        $display("Fail %s expected %0d actual %0d", name, expected, actual);
    endtask

    task automatic check_transfer();
        if (exp_value.size() == 0) begin
            other_errors++;
            $display("value %0h on channel %0d came out with nothing left to expect",
                     o_value, o_value_channel);
        end else begin
            if (o_value !== exp_value[0])
                report_mismatch("decode value", int'(exp_value[0]), int'(o_value));
            if (o_value_channel !== exp_channel[0])
                report_mismatch("decode channel", int'(exp_channel[0]), int'(o_value_channel));
            if (o_value_column !== exp_column[0])
                report_mismatch("decode column", int'(exp_column[0]), int'(o_value_column));
            if (o_last_column !== exp_last[0])
                report_mismatch("last column", int'(exp_last[0]), int'(o_last_column));
            void'(exp_value.pop_front());
            void'(exp_channel.pop_front());
            void'(exp_column.pop_front());
            void'(exp_last.pop_front());
        end
    endtask

    // one output transfer per edge with valid and ready high
    always @(posedge clk) begin
        if (resetn) begin
            if (held && (!o_value_valid
                    || held_output !== {o_value, o_value_channel, o_value_column})) begin
                other_errors++;
                $display("stalled value changed or dropped before its transfer at %0t", $time);
            end
            held = o_value_valid && !i_value_ready;
            held_output = {o_value, o_value_channel, o_value_column};
            if (o_value_valid && i_value_ready)
                check_transfer();
        end
    end

    task automatic send_word(input logic [63:0] word);
        repeat ($urandom % 3) begin
            @(posedge clk);
            #1;
        end
        i_stream_data = word;
        i_stream_valid = 1'b1;
        // ready seen between edges means the next edge takes the word
        while (!o_stream_ready) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        i_stream_valid = 1'b0;
        i_stream_data = {$urandom, $urandom};
    endtask

    task automatic run_layer(input int groups, input int columns, input int words);
        i_num_channels_minus_8 = 10'(groups * 8 - 8);
        i_num_columns = 9'(columns);
        i_start = 1'b1;
        @(posedge clk);
        #1;
        i_start = 1'b0;
        for (int w = 0; w < words; w++)
            send_word(stream_words.pop_front());
        // the buffer only empties once the final group has flushed it
        while (!o_stream_ready) begin
            @(posedge clk);
            #1;
        end
    endtask

    // random back-pressure on the output side
    initial begin
        forever begin
            @(posedge clk);
            #1;
            if (resetn)
                i_value_ready = ($urandom % 4) != 0;
        end
    end

    initial begin
        wait (timeout_cycles > 0);
        repeat (timeout_cycles) @(posedge clk);
        $display("timeout, the decoder did not finish all layers in %0d cycles", timeout_cycles);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'h4ed7_3123));
        clk = 1'b0;
        resetn = 1'b0;
        i_start = 1'b0;
        i_num_channels_minus_8 = '0;
        i_num_columns = 9'd1;
        i_stream_data = '0;
        i_stream_valid = 1'b0;
        i_value_ready = 1'b0;
        value_errors = 0;
        other_errors = 0;
        held = 1'b0;
        held_output = '0;
        for (int l = 0; l < NUM_LAYERS; l++)
            build_layer(1 + int'($urandom % 5), 1 + int'($urandom % 4));
        timeout_cycles = stream_words.size() * 8 * 4 + 200;
        repeat (3) @(posedge clk);
        #1;
        resetn = 1'b1;
        @(posedge clk);
        #1;
        if (o_value_valid !== 1'b0)
            report_mismatch("reset valid", 0, int'(o_value_valid));
        if (o_stream_ready !== 1'b1)
            report_mismatch("reset ready", 1, int'(o_stream_ready));
        for (int l = 0; l < NUM_LAYERS; l++)
            run_layer(layer_groups[l], layer_columns[l], layer_word_count[l]);
        repeat (20) @(posedge clk);
        if (exp_value.size() != 0) begin
            other_errors++;
            $display("%0d expected values never came out", exp_value.size());
        end
        $display("value errors %0d, other errors %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+test
verilog/decoder_cfg_pkg.sv
verilog/stream_format_pkg.sv
verilog/stream_word_buffer.sv
verilog/sparsity_map_decoder.sv
verilog/layer_position_tracker.sv
verilog/decode_control.sv
verilog/compressed_stream_decoder.sv
test/tb_compressed_stream_decoder.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_compressed_stream_decoder \
    -f src.f -o sim_tb
./obj_dir/sim_tb > sim.log
cat sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
